// File: all.f
+incdir+src
src/translate_pkg.sv
src/translation_cache.sv
src/page_walker.sv
src/translate_top.sv
tests/bus_memory_model.sv
tests/tb_translate.sv

// File: run.sh
#!/bin/sh
# Build the translation unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_translate

output=$(./obj_dir/Vtb_translate || true)
echo "$output"
echo "$output" | grep -q "TEST OK"
echo "simulation passed"

// File: src/page_walker.sv
`timescale 1ns/10ps
`include "translate_settings.svh"

module page_walker
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        walk_req,
    output logic                        walk_ack,
    input  logic [`TR_DATA_WIDTH-1:0]   virt_addr,
    input  logic [`TR_DATA_WIDTH-1:0]   ptbr,
    output translate_pkg::walk_result_t result,
    output logic                        abtr_reqcyc,
    input  logic                        abtr_grant,
    output logic                        bus_busy,
    output logic                        main_bus_reqcyc,
    output logic [`TR_DATA_WIDTH-1:0]   main_bus_req,
    output logic [`TR_TAG_WIDTH-1:0]    main_bus_reqtag,
    input  logic                        main_bus_respcyc,
    input  logic [`TR_DATA_WIDTH-1:0]   main_bus_resp,
    input  logic [`TR_TAG_WIDTH-1:0]    main_bus_resptag,
    output logic                        main_bus_respack
);
    localparam int DATA_W  = `TR_DATA_WIDTH;
    localparam int LEVEL_W = $clog2(`TR_LEVELS);
    localparam int BEAT_W  = $clog2(`TR_BURST_BEATS);

    typedef enum logic [2:0] {
        ST_RESET,
        ST_BEGIN,
        ST_REQ,
        ST_WAIT,
        ST_RESP,
        ST_READY
    } state_t;

    state_t                       state;
    logic [LEVEL_W-1:0]           level;
    logic [BEAT_W-1:0]            beat_cnt;
    logic [DATA_W-1:0]            entry_addr;  // Address of the entry for this level
    translate_pkg::pte_t          pte_q;
    translate_pkg::pte_t          beat_pte;
    translate_pkg::pte_t          sel_pte;
    logic                         beat_in;
    logic                         beat_sel;
    logic                         last_beat;
    logic                         last_level;
    logic [`TR_INDEX_WIDTH-1:0]   next_index;

    // Table index taken from the virtual address at each level
    function automatic logic [`TR_INDEX_WIDTH-1:0] level_index(
        input logic [LEVEL_W-1:0]  lvl,
        input logic [DATA_W-1:0]   va
    );
        case (lvl)
            2'd0:    level_index = va[38:30];
            2'd1:    level_index = va[29:21];
            default: level_index = va[20:12];
        endcase
    endfunction

    // *************************************************************************
    // Burst beat handling
    // *************************************************************************

    assign beat_in    = main_bus_respcyc && (state == ST_WAIT || state == ST_RESP);
    assign beat_sel   = (beat_cnt == entry_addr[5:3]);
    assign last_beat  = beat_in && (beat_cnt == BEAT_W'(`TR_BURST_BEATS - 1));
    assign last_level = (level == LEVEL_W'(`TR_LEVELS - 1));
    assign next_index = level_index(level + 1'b1, virt_addr);

    // A beat with the wrong tag reads as an invalid entry
    assign beat_pte = (main_bus_resptag == `TR_TAG_READ_MEM) ?
                      translate_pkg::pte_t'(main_bus_resp) : '0;

    // Selected beat may be the last one of the burst
    assign sel_pte = beat_sel ? beat_pte : pte_q;

    // *************************************************************************
    // Bus side
    // *************************************************************************

    assign bus_busy         = (state == ST_REQ) || (state == ST_WAIT) || (state == ST_RESP);
    assign abtr_reqcyc      = (state == ST_BEGIN) || bus_busy;
    assign main_bus_reqcyc  = (state == ST_REQ);
    assign main_bus_req     = {entry_addr[DATA_W-1:6], 6'b0};  // Line aligned
    assign main_bus_reqtag  = `TR_TAG_READ_MEM;
    assign main_bus_respack = beat_in;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= ST_RESET;
            level    <= '0;
            beat_cnt <= '0;
            walk_ack <= 1'b0;
        end
        else
        begin
            case (state)
                ST_RESET:
                begin
                    if (walk_req)
                    begin
                        level      <= '0;
                        entry_addr <= ptbr + (DATA_W'(level_index('0, virt_addr)) << 3);
                        state      <= ST_BEGIN;
                    end
                end
                ST_BEGIN:
                begin
                    if (abtr_grant)
                        state <= ST_REQ;
                end
                ST_REQ:
                begin
                    beat_cnt <= '0;
                    state    <= ST_WAIT;
                end
                ST_WAIT, ST_RESP:
                begin
                    if (beat_in)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        state    <= ST_RESP;
                        if (beat_sel)
                            pte_q <= beat_pte;
                        if (last_beat)
                        begin
                            if (!sel_pte.valid || last_level)
                            begin
                                result.ppn   <= sel_pte.ppn;
                                result.fault <= !sel_pte.valid;
                                walk_ack     <= 1'b1;
                                state        <= ST_READY;  // Bus released here
                            end
                            else
                            begin
                                level      <= level + 1'b1;
                                entry_addr <= (DATA_W'(sel_pte.ppn) << `TR_PAGE_SHIFT) +
                                              (DATA_W'(next_index) << 3);
                                state      <= ST_REQ;
                            end
                        end
                    end
                end
                ST_READY:
                begin
                    if (!walk_req)
                    begin
                        walk_ack <= 1'b0;
                        state    <= ST_RESET;
                    end
                end
                default:
                    state <= ST_RESET;
            endcase
        end
    end

endmodule

// File: src/translate_pkg.sv
`include "translate_settings.svh"

package translate_pkg;

    // Client side
    typedef struct packed {
        logic [`TR_DATA_WIDTH-1:0] virt_addr;
    } trans_req_t;

    typedef struct packed {
        logic [`TR_DATA_WIDTH-1:0] phys_addr;
        logic                      fault;
        logic                      hit;        // Answer came from the cache
    } trans_resp_t;

    // Page table entry as it sits in memory
    typedef struct packed {
        logic [9:0]               reserved;   // Bits 63:54
        logic [`TR_PPN_WIDTH-1:0] ppn;        // Bits 53:10
        logic [8:0]               flags;
        logic                     valid;      // Bit 0
    } pte_t;

    typedef struct packed {
        logic                     valid;
        logic [`TR_VPN_WIDTH-1:0] vpn;
        logic [`TR_PPN_WIDTH-1:0] ppn;
    } cache_entry_t;

    // Leaf page number, or fault at the level where the walk stopped
    typedef struct packed {
        logic [`TR_PPN_WIDTH-1:0] ppn;
        logic                     fault;
    } walk_result_t;

endpackage

// File: src/translate_settings.svh
`ifndef TRANSLATE_SETTINGS_SVH
`define TRANSLATE_SETTINGS_SVH

// Bus word and address width
`define TR_DATA_WIDTH     64
`define TR_TAG_WIDTH      13

// Read flag in bit 12 and memory target in bits 11:8
`define TR_TAG_READ_MEM   13'h1100

`define TR_BURST_BEATS    8

// Three levels of 9 index bits over 4 KiB pages
`define TR_LEVELS         3
`define TR_INDEX_WIDTH    9
`define TR_PAGE_SHIFT     12
`define TR_VPN_WIDTH      27
`define TR_PPN_WIDTH      44

`define TR_CACHE_ENTRIES  4

`endif

// File: src/translate_top.sv
`timescale 1ns/10ps
`include "translate_settings.svh"

module translate_top
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req,
    output logic                        ack,
    input  translate_pkg::trans_req_t   request,
    output translate_pkg::trans_resp_t  response,
    input  logic [`TR_DATA_WIDTH-1:0]   ptbr,
    output logic                        abtr_reqcyc,
    input  logic                        abtr_grant,
    output logic                        bus_busy,
    output logic                        main_bus_reqcyc,
    output logic [`TR_DATA_WIDTH-1:0]   main_bus_req,
    output logic [`TR_TAG_WIDTH-1:0]    main_bus_reqtag,
    input  logic                        main_bus_respcyc,
    input  logic [`TR_DATA_WIDTH-1:0]   main_bus_resp,
    input  logic [`TR_TAG_WIDTH-1:0]    main_bus_resptag,
    output logic                        main_bus_respack
);
    localparam int DATA_W = `TR_DATA_WIDTH;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WALK,
        S_ANSWER,
        S_RELEASE
    } state_t;

    state_t                       state;
    logic                         lookup_hit;
    logic [`TR_PPN_WIDTH-1:0]     lookup_ppn;
    logic                         walk_req;
    logic                         walk_ack;
    translate_pkg::walk_result_t  walk_result;
    logic                         fill_valid;
    logic [`TR_VPN_WIDTH-1:0]     vpn;

    // Page number joined with the page offset, zero on a fault
    function automatic translate_pkg::trans_resp_t make_resp(
        input logic [`TR_PPN_WIDTH-1:0]   ppn,
        input logic [`TR_PAGE_SHIFT-1:0]  offset,
        input logic                       fault,
        input logic                       hit
    );
        translate_pkg::trans_resp_t r;
        r.phys_addr = fault ? '0 : DATA_W'({ppn, offset});
        r.fault     = fault;
        r.hit       = hit;
        return r;
    endfunction

    assign vpn        = request.virt_addr[`TR_PAGE_SHIFT +: `TR_VPN_WIDTH];
    assign fill_valid = (state == S_WALK) && walk_ack && !walk_result.fault;

    // *************************************************************************
    // Client handshake
    // *************************************************************************

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= S_IDLE;
            ack      <= 1'b0;
            walk_req <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (req)
                        state <= S_LOOKUP;  // Cache result registers this edge
                end
                S_LOOKUP:
                begin
                    if (lookup_hit)
                    begin
                        response <= make_resp(lookup_ppn,
                                              request.virt_addr[`TR_PAGE_SHIFT-1:0],
                                              1'b0, 1'b1);
                        ack      <= 1'b1;
                        state    <= S_ANSWER;
                    end
                    else
                    begin
                        walk_req <= 1'b1;
                        state    <= S_WALK;
                    end
                end
                S_WALK:
                begin
                    if (walk_ack)
                    begin
                        response <= make_resp(walk_result.ppn,
                                              request.virt_addr[`TR_PAGE_SHIFT-1:0],
                                              walk_result.fault, 1'b0);
                        walk_req <= 1'b0;
                        ack      <= 1'b1;
                        state    <= S_ANSWER;
                    end
                end
                S_ANSWER:
                begin
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE:
                begin
                    // Walker must close its own handshake first
                    if (!walk_ack)
                        state <= S_IDLE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    translation_cache cache0
    (
        .clk        (clk),
        .reset      (reset),
        .lookup_vpn (vpn),
        .lookup_hit (lookup_hit),
        .lookup_ppn (lookup_ppn),
        .fill_valid (fill_valid),
        .fill_vpn   (vpn),
        .fill_ppn   (walk_result.ppn)
    );

    page_walker walker0
    (
        .clk              (clk),
        .reset            (reset),
        .walk_req         (walk_req),
        .walk_ack         (walk_ack),
        .virt_addr        (request.virt_addr),
        .ptbr             (ptbr),
        .result           (walk_result),
        .abtr_reqcyc      (abtr_reqcyc),
        .abtr_grant       (abtr_grant),
        .bus_busy         (bus_busy),
        .main_bus_reqcyc  (main_bus_reqcyc),
        .main_bus_req     (main_bus_req),
        .main_bus_reqtag  (main_bus_reqtag),
        .main_bus_respcyc (main_bus_respcyc),
        .main_bus_resp    (main_bus_resp),
        .main_bus_resptag (main_bus_resptag),
        .main_bus_respack (main_bus_respack)
    );

endmodule

// File: src/translation_cache.sv
`timescale 1ns/10ps
`include "translate_settings.svh"

module translation_cache
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`TR_VPN_WIDTH-1:0]  lookup_vpn,
    output logic                      lookup_hit,
    output logic [`TR_PPN_WIDTH-1:0]  lookup_ppn,
    input  logic                      fill_valid,
    input  logic [`TR_VPN_WIDTH-1:0]  fill_vpn,
    input  logic [`TR_PPN_WIDTH-1:0]  fill_ppn
);
    localparam int PTR_W = $clog2(`TR_CACHE_ENTRIES);

    translate_pkg::cache_entry_t  entries [`TR_CACHE_ENTRIES];
    logic [PTR_W-1:0]             rr_ptr;      // Next entry to replace
    logic                         match_any;
    logic [`TR_PPN_WIDTH-1:0]     match_ppn;

    // *************************************************************************
    // Parallel compare
    // *************************************************************************

    always_comb
    begin
        match_any = 1'b0;
        match_ppn = '0;
        for (int i = 0; i < `TR_CACHE_ENTRIES; i++)
        begin
            if (entries[i].valid && entries[i].vpn == lookup_vpn)
            begin
                match_any = 1'b1;
                match_ppn = match_ppn | entries[i].ppn;  // Fills only follow a miss
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            lookup_hit <= 1'b0;
        else
            lookup_hit <= match_any;
        lookup_ppn <= match_ppn;
    end

    // *************************************************************************
    // Fill with round-robin replacement
    // *************************************************************************

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rr_ptr <= '0;
            for (int i = 0; i < `TR_CACHE_ENTRIES; i++)
                entries[i].valid <= 1'b0;
        end
        else if (fill_valid)
        begin
            entries[rr_ptr] <= '{valid: 1'b1, vpn: fill_vpn, ppn: fill_ppn};
            if (rr_ptr == PTR_W'(`TR_CACHE_ENTRIES - 1))
                rr_ptr <= '0;
            else
                rr_ptr <= rr_ptr + 1'b1;
        end
    end

endmodule

// File: tests/bus_memory_model.sv
`timescale 1ns/10ps
`include "translate_settings.svh"

module bus_memory_model
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       abtr_reqcyc,
    output logic                       abtr_grant,
    input  logic                       main_bus_reqcyc,
    input  logic [`TR_DATA_WIDTH-1:0]  main_bus_req,
    output logic                       main_bus_respcyc,
    output logic [`TR_DATA_WIDTH-1:0]  main_bus_resp,
    output logic [`TR_TAG_WIDTH-1:0]   main_bus_resptag
);
    logic [`TR_DATA_WIDTH-1:0] pt_words [logic [`TR_DATA_WIDTH-1:0]];  // Sparse page table
    integer seed = 2179;

    // Unmapped words get an address hash with the valid bit clear
    function automatic logic [`TR_DATA_WIDTH-1:0] read_word(
        input logic [`TR_DATA_WIDTH-1:0] addr
    );
        if (pt_words.exists(addr))
            return pt_words[addr];
        return (addr * 64'h9E37_79B9_7F4A_7C15) & ~64'h1;
    endfunction

    // *************************************************************************
    // Arbiter
    // *************************************************************************

    initial
    begin
        int delay;
        abtr_grant = 1'b0;
        forever
        begin
            @(posedge clk);
            if (reset || !abtr_reqcyc)
                abtr_grant <= 1'b0;
            else if (!abtr_grant)
            begin
                delay = {$random(seed)} % 6;  // 0 to 5 cycles
                repeat (delay) @(posedge clk);
                abtr_grant <= 1'b1;
            end
        end
    end

    // *************************************************************************
    // Line reads
    // *************************************************************************

    initial
    begin
        logic [`TR_DATA_WIDTH-1:0] line_addr;
        int delay;
        main_bus_respcyc = 1'b0;
        main_bus_resp    = '0;
        main_bus_resptag = '0;
        forever
        begin
            @(posedge clk);
            if (!reset && main_bus_reqcyc)
            begin
                line_addr = main_bus_req;
                delay = 1 + {$random(seed)} % 4;
                repeat (delay - 1) @(posedge clk);
                for (int b = 0; b < `TR_BURST_BEATS; b++)
                begin
                    main_bus_respcyc <= 1'b1;
                    main_bus_resp    <= read_word(line_addr + 64'(b * 8));
                    main_bus_resptag <= `TR_TAG_READ_MEM;
                    @(posedge clk);
                end
                main_bus_respcyc <= 1'b0;
                main_bus_resptag <= '0;
            end
        end
    end

endmodule

// File: tests/tb_translate.sv
`timescale 1ns/10ps
`include "translate_settings.svh"

module tb_translate;

    localparam int RESET_CYCLES = 16;
    localparam int ROWS         = 18;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + ROWS * 200;
    localparam logic [`TR_DATA_WIDTH-1:0] ROOT_BASE = 64'h0000_0000_0001_0000;

    typedef struct packed {
        logic [`TR_DATA_WIDTH-1:0] virt_addr;
        logic [`TR_DATA_WIDTH-1:0] phys_addr;
        logic                      fault;
        logic                      hit;
        logic [1:0]                bus_reads;  // Line reads for this request
    } vector_t;

    logic                        clk;
    logic                        reset;
    logic                        req;
    logic                        ack;
    translate_pkg::trans_req_t   request;
    translate_pkg::trans_resp_t  response;
    logic [`TR_DATA_WIDTH-1:0]   ptbr;
    logic                        abtr_reqcyc;
    logic                        abtr_grant;
    logic                        bus_busy;
    logic                        main_bus_reqcyc;
    logic [`TR_DATA_WIDTH-1:0]   main_bus_req;
    logic [`TR_TAG_WIDTH-1:0]    main_bus_reqtag;
    logic                        main_bus_respcyc;
    logic [`TR_DATA_WIDTH-1:0]   main_bus_resp;
    logic [`TR_TAG_WIDTH-1:0]    main_bus_resptag;
    logic                        main_bus_respack;
    int                          cycle_count = 0;
    int                          read_count  = 0;

    vector_t vectors [ROWS] = '{
        '{64'h0000_0000_4040_3123, 64'h0000_0000_4000_1123, 1'b0, 1'b0, 2'd3},
        '{64'h0000_0000_4040_3FF8, 64'h0000_0000_4000_1FF8, 1'b0, 1'b1, 2'd0},
        '{64'h0000_0000_C000_1234, 64'h0, 1'b1, 1'b0, 2'd1},  // Fault at level 1
        '{64'h0000_0000_C000_1234, 64'h0, 1'b1, 1'b0, 2'd1},
        '{64'h0000_0000_40E0_0ABC, 64'h0, 1'b1, 1'b0, 2'd2},  // Level 2
        '{64'h0000_0000_4040_8010, 64'h0, 1'b1, 1'b0, 2'd3},  // Level 3
        '{64'h0000_0000_4040_8010, 64'h0, 1'b1, 1'b0, 2'd3},
        '{64'h0000_0000_4040_4004, 64'h0000_0000_4000_2004, 1'b0, 1'b0, 2'd3},
        '{64'h0000_0000_4040_5008, 64'h0000_0000_4000_3008, 1'b0, 1'b0, 2'd3},
        '{64'h0000_0000_40A0_700C, 64'h0000_0000_4000_400C, 1'b0, 1'b0, 2'd3},
        '{64'h0000_0000_8000_9010, 64'h0000_0000_4000_5010, 1'b0, 1'b0, 2'd3},
        '{64'h0000_0000_4040_4FFC, 64'h0000_0000_4000_2FFC, 1'b0, 1'b1, 2'd0},
        '{64'h0000_0000_4040_5100, 64'h0000_0000_4000_3100, 1'b0, 1'b1, 2'd0},
        '{64'h0000_0000_40A0_7800, 64'h0000_0000_4000_4800, 1'b0, 1'b1, 2'd0},
        '{64'h0000_0000_8000_9FF0, 64'h0000_0000_4000_5FF0, 1'b0, 1'b1, 2'd0},
        '{64'h0000_0000_4040_3456, 64'h0000_0000_4000_1456, 1'b0, 1'b0, 2'd3},  // Evicted
        '{64'h0000_0000_4040_3789, 64'h0000_0000_4000_1789, 1'b0, 1'b1, 2'd0},
        '{64'h0000_0000_4040_4000, 64'h0000_0000_4000_2000, 1'b0, 1'b0, 2'd3}
    };

    always #2 clk = ~clk;

    translate_top dut0
    (
        .clk              (clk),
        .reset            (reset),
        .req              (req),
        .ack              (ack),
        .request          (request),
        .response         (response),
        .ptbr             (ptbr),
        .abtr_reqcyc      (abtr_reqcyc),
        .abtr_grant       (abtr_grant),
        .bus_busy         (bus_busy),
        .main_bus_reqcyc  (main_bus_reqcyc),
        .main_bus_req     (main_bus_req),
        .main_bus_reqtag  (main_bus_reqtag),
        .main_bus_respcyc (main_bus_respcyc),
        .main_bus_resp    (main_bus_resp),
        .main_bus_resptag (main_bus_resptag),
        .main_bus_respack (main_bus_respack)
    );

    bus_memory_model mem0
    (
        .clk              (clk),
        .reset            (reset),
        .abtr_reqcyc      (abtr_reqcyc),
        .abtr_grant       (abtr_grant),
        .main_bus_reqcyc  (main_bus_reqcyc),
        .main_bus_req     (main_bus_req),
        .main_bus_respcyc (main_bus_respcyc),
        .main_bus_resp    (main_bus_resp),
        .main_bus_resptag (main_bus_resptag)
    );

    task automatic check_value(
        input string                      name,
        input logic [`TR_DATA_WIDTH-1:0]  actual,
        input logic [`TR_DATA_WIDTH-1:0]  expected
    );
        if (actual !== expected)
        begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Valid bit in bit 0, page number in bits 53:10
    task automatic set_pte(
        input logic [`TR_DATA_WIDTH-1:0]  addr,
        input logic [`TR_PPN_WIDTH-1:0]   ppn,
        input logic                       valid
    );
        mem0.pt_words[addr] = {10'b0, ppn, 9'b0, valid};
    endtask

    task automatic load_page_table();
        set_pte(64'h1_0008, 44'h20, 1'b1);     // Root
        set_pte(64'h1_0010, 44'h21, 1'b1);
        set_pte(64'h1_0018, 44'h22, 1'b0);
        set_pte(64'h2_0010, 44'h30, 1'b1);     // Second level
        set_pte(64'h2_0028, 44'h31, 1'b1);
        set_pte(64'h2_0038, 44'h32, 1'b0);
        set_pte(64'h2_1000, 44'h33, 1'b1);
        set_pte(64'h3_0018, 44'h4_0001, 1'b1); // Leaves
        set_pte(64'h3_0020, 44'h4_0002, 1'b1);
        set_pte(64'h3_0028, 44'h4_0003, 1'b1);
        set_pte(64'h3_0040, 44'h4_0009, 1'b0);
        set_pte(64'h3_1038, 44'h4_0004, 1'b1);
        set_pte(64'h3_3048, 44'h4_0005, 1'b1);
    endtask

    task automatic check_answer(input vector_t v);
        check_value("ack", ack, 1);
        check_value("response.phys_addr", response.phys_addr, v.phys_addr);
        check_value("response.fault", response.fault, v.fault);
        check_value("response.hit", response.hit, v.hit);
    endtask

    // *************************************************************************
    // Four-phase handshake for one table row
    // *************************************************************************

    task automatic run_row(input vector_t v, input int row);
        int reads_before;
        int latency;
        reads_before = read_count;
        latency      = 0;
        request.virt_addr <= v.virt_addr;
        req               <= 1'b1;
        @(posedge clk);
        while (!ack)
        begin
            @(posedge clk);
            latency++;
        end
        check_answer(v);
        check_value("bus read count", read_count - reads_before, v.bus_reads);
        if (v.hit)
            check_value("hit latency", latency, 2);
        // Client holds req a while and the answer stays put
        repeat (row % 3)
        begin
            @(posedge clk);
            check_answer(v);
        end
        req <= 1'b0;
        @(posedge clk);
        while (ack)
            @(posedge clk);
    endtask

    // Bus side rules
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (ack)
            begin
                check_value("abtr_reqcyc", abtr_reqcyc, 0);
                check_value("bus_busy", bus_busy, 0);
            end
            if (main_bus_reqcyc || main_bus_respcyc)
                check_value("bus_busy", bus_busy, 1);
            if (main_bus_reqcyc)
            begin
                read_count <= read_count + 1;
                check_value("main_bus_reqtag", main_bus_reqtag, `TR_TAG_READ_MEM);
                check_value("main_bus_req[5:0]", main_bus_req[5:0], 0);
            end
            if (main_bus_respcyc)
                check_value("main_bus_respack", main_bus_respack, 1);
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: no answer from the DUT after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    initial
    begin
        clk     = 1'b0;
        reset   = 1'b1;
        req     = 1'b0;
        request = '0;
        ptbr    = ROOT_BASE;
        load_page_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < ROWS; i++)
            run_row(vectors[i], i);
        $display("TEST OK");
        $finish;
    end

endmodule
